/* design/mcu_ao_pkg.sv */
// Widths, bit positions and the machine interrupt word for the always-on block.
// The word layout follows the RISC-V mip register with sixteen fast lines.

package mcu_ao_pkg;

  localparam int unsigned IRQ_W  = 32;
  localparam int unsigned FAST_W = 16;

  // level sources in the interrupt word
  localparam int unsigned IRQ_SW_BIT    = 3;
  localparam int unsigned IRQ_TIMER_BIT = 7;
  localparam int unsigned IRQ_EXT_BIT   = 11;

  // fast field occupies [30:15]
  localparam int unsigned IRQ_FAST_LSB = 15;

  // idle cycles before the domain is switched off
  localparam int unsigned IDLE_CYCLES_DEFAULT = 8;

  // raw view for the core, field view for the collector
  typedef union packed {
    logic [IRQ_W-1:0] raw;
    struct packed {
      logic              rsvd;
      logic [FAST_W-1:0] fast;
      logic [2:0]        zero3;
      logic              ext;
      logic [2:0]        zero2;
      logic              timer;
      logic [2:0]        zero1;
      logic              sw;
      logic [2:0]        zero0;
    } f;
  } irq_vec_u;

endpackage

/* design/irq_collector.sv */
// Fast sources are one-cycle pulses, held until cleared; levels are sampled as is.
// All inputs are assumed synchronous to clk_i.

`timescale 1ns/1ps

module irq_collector (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          irq_software_i,
  input  logic                          irq_timer_i,
  input  logic                          irq_external_i,
  input  logic [mcu_ao_pkg::FAST_W-1:0] fast_src_i,
  input  logic [mcu_ao_pkg::FAST_W-1:0] fast_clear_i,
  output mcu_ao_pkg::irq_vec_u          irq_o,
  output logic                          irq_pending_o
);

  mcu_ao_pkg::irq_vec_u          irq_q;
  mcu_ao_pkg::irq_vec_u          irq_d;
  logic [mcu_ao_pkg::FAST_W-1:0] fast_pend_d;

  // the fast field of the word register doubles as the pending register
  // a pulse arriving together with its clear keeps the bit set
  assign fast_pend_d = (irq_q.f.fast & ~fast_clear_i) | fast_src_i;

  always_comb begin
    irq_d = '0;

    // reserved and padding bits are never written
    irq_d.f.rsvd  = 1'b0;
    irq_d.f.zero3 = 3'b000;
    irq_d.f.zero2 = 3'b000;
    irq_d.f.zero1 = 3'b000;
    irq_d.f.zero0 = 3'b000;

    // level sources, one cycle late
    irq_d.f.sw    = irq_software_i;
    irq_d.f.timer = irq_timer_i;
    irq_d.f.ext   = irq_external_i;

    irq_d.f.fast  = fast_pend_d;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      irq_q <= '0;
    end else begin
      irq_q <= irq_d;
    end
  end

  assign irq_o = irq_q;

  // any bit set in the registered word
  assign irq_pending_o = |irq_q.raw;

endmodule

/* design/power_domain_seq.sv */
// One power-gated domain. switch_ack_ni must already be synchronous to clk_i.
// A request that drops mid power-down is served only once the switch reports off.

`timescale 1ns/1ps

module power_domain_seq (
  input  logic clk_i,
  input  logic reset_i,
  input  logic power_off_req_i,
  input  logic switch_ack_ni,
  output logic switch_no,
  output logic iso_no,
  output logic rst_no,
  output logic clkgate_en_no,
  output logic domain_on_o
);

  typedef enum logic [3:0] {
    ST_ON,
    ST_CLK_GATED,
    ST_ISOLATED,
    ST_IN_RESET,
    ST_WAIT_OFF,
    ST_OFF,
    ST_WAIT_ON,
    ST_RST_RELEASED,
    ST_ISO_RELEASED
  } state_e;

  state_e state_q;

  logic switch_q;
  logic iso_q;
  logic rst_q;
  logic clkgate_q;
  logic domain_on_q;

  // each control changes on a state transition, so all come from flops
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= ST_ON;
      switch_q    <= 1'b1;
      iso_q       <= 1'b1;
      rst_q       <= 1'b1;
      clkgate_q   <= 1'b1;
      domain_on_q <= 1'b1;
    end else begin
      case (state_q)
        ST_ON: begin
          if (power_off_req_i) begin
            clkgate_q   <= 1'b0;
            domain_on_q <= 1'b0;
            state_q     <= ST_CLK_GATED;
          end
        end

        ST_CLK_GATED: begin
          iso_q   <= 1'b0;
          state_q <= ST_ISOLATED;
        end

        ST_ISOLATED: begin
          rst_q   <= 1'b0;
          state_q <= ST_IN_RESET;
        end

        ST_IN_RESET: begin
          switch_q <= 1'b0;
          state_q  <= ST_WAIT_OFF;
        end

        // switch cells report off with ack high
        ST_WAIT_OFF: begin
          if (switch_ack_ni) begin
            state_q <= ST_OFF;
          end
        end

        ST_OFF: begin
          if (!power_off_req_i) begin
            switch_q <= 1'b1;
            state_q  <= ST_WAIT_ON;
          end
        end

        // supply is good once ack goes low again
        ST_WAIT_ON: begin
          if (!switch_ack_ni) begin
            rst_q   <= 1'b1;
            state_q <= ST_RST_RELEASED;
          end
        end

        ST_RST_RELEASED: begin
          iso_q   <= 1'b1;
          state_q <= ST_ISO_RELEASED;
        end

        ST_ISO_RELEASED: begin
          clkgate_q   <= 1'b1;
          domain_on_q <= 1'b1;
          state_q     <= ST_ON;
        end

        default: begin
          state_q <= ST_ON;
        end
      endcase
    end
  end

  assign switch_no     = switch_q;
  assign iso_no        = iso_q;
  assign rst_no        = rst_q;
  assign clkgate_en_no = clkgate_q;
  assign domain_on_o   = domain_on_q;

endmodule

/* design/wake_ctrl.sv */
// Sleep policy for the gated domain. IDLE_CYCLES must be at least 1.
// wakeup_o is combinational and pulses in the cycle domain_on_i returns high.

`timescale 1ns/1ps

module wake_ctrl #(
  parameter int unsigned IDLE_CYCLES = mcu_ao_pkg::IDLE_CYCLES_DEFAULT
) (
  input  logic clk_i,
  input  logic reset_i,
  input  logic core_sleep_i,
  input  logic sleep_enable_i,
  input  logic irq_pending_i,
  input  logic domain_on_i,
  output logic power_off_req_o,
  output logic wakeup_o
);

  localparam int unsigned CNT_W = $clog2(IDLE_CYCLES + 1);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(IDLE_CYCLES - 1);

  logic             idle;
  logic [CNT_W-1:0] idle_cnt_q;
  logic             req_q;
  logic             went_off_q;

  assign idle = core_sleep_i & sleep_enable_i & ~irq_pending_i;

  // consecutive idle cycles, saturating
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      idle_cnt_q <= '0;
    end else if (!idle) begin
      idle_cnt_q <= '0;
    end else if (idle_cnt_q != CNT_LAST) begin
      idle_cnt_q <= idle_cnt_q + 1'b1;
    end
  end

  // held until an interrupt shows up or the core wakes on its own
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_q <= 1'b0;
    end else if (req_q && (irq_pending_i || !core_sleep_i)) begin
      req_q <= 1'b0;
    end else if (idle && idle_cnt_q == CNT_LAST) begin
      req_q <= 1'b1;
    end
  end

  // domain was off in the previous cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      went_off_q <= 1'b0;
    end else begin
      went_off_q <= ~domain_on_i;
    end
  end

  assign power_off_req_o = req_q;
  assign wakeup_o        = domain_on_i & went_off_q;

endmodule

/* design/mcu_ao_ctrl.sv */
// Always-on control: interrupt collection, domain power sequencing and wake-up.
// switch_ack_ni comes from the switch cells and must be synchronous to clk_i.

`timescale 1ns/1ps

module mcu_ao_ctrl #(
  parameter int unsigned IDLE_CYCLES = mcu_ao_pkg::IDLE_CYCLES_DEFAULT
) (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          irq_software_i,
  input  logic                          irq_timer_i,
  input  logic                          irq_external_i,
  input  logic [mcu_ao_pkg::FAST_W-1:0] fast_src_i,
  input  logic [mcu_ao_pkg::FAST_W-1:0] fast_clear_i,
  input  logic                          core_sleep_i,
  input  logic                          sleep_enable_i,
  input  logic                          switch_ack_ni,
  output mcu_ao_pkg::irq_vec_u          irq_o,
  output logic                          irq_pending_o,
  output logic                          switch_no,
  output logic                          iso_no,
  output logic                          rst_no,
  output logic                          clkgate_en_no,
  output logic                          domain_on_o,
  output logic                          wakeup_o
);

  logic power_off_req;

  irq_collector irq_collector_i (
    .clk_i,
    .reset_i,
    .irq_software_i,
    .irq_timer_i,
    .irq_external_i,
    .fast_src_i,
    .fast_clear_i,
    .irq_o,
    .irq_pending_o
  );

  wake_ctrl #(
    .IDLE_CYCLES(IDLE_CYCLES)
  ) wake_ctrl_i (
    .clk_i,
    .reset_i,
    .core_sleep_i,
    .sleep_enable_i,
    .irq_pending_i  (irq_pending_o),
    .domain_on_i    (domain_on_o),
    .power_off_req_o(power_off_req),
    .wakeup_o
  );

  power_domain_seq power_domain_seq_i (
    .clk_i,
    .reset_i,
    .power_off_req_i(power_off_req),
    .switch_ack_ni,
    .switch_no,
    .iso_no,
    .rst_no,
    .clkgate_en_no,
    .domain_on_o
  );

endmodule

/* bench/tb_vectors.svh */
// Columns are sw, timer, ext, fast pulse mask, fast clear mask, core sleep,
// sleep enable, hold cycles and the domain state expected at the end of the row.
// Both masks are driven in the first cycle of a row only.

`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

localparam logic [1:0] EXP_OFF   = 2'd0;
localparam logic [1:0] EXP_ON    = 2'd1;
localparam logic [1:0] EXP_GOING = 2'd2;

typedef struct packed {
  logic        sw;
  logic        timer;
  logic        ext;
  logic [15:0] fast_set;
  logic [15:0] fast_clr;
  logic        sleep;
  logic        sleep_en;
  logic [7:0]  cycles;
  logic [1:0]  expect_dom;
} row_t;

localparam int N_ROWS = 25;

localparam row_t VECTORS [N_ROWS] = '{
  // level sources one at a time, then together
  '{1'b0, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b0, 1'b0, 8'd4,  EXP_ON},
  '{1'b1, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b0, 1'b0, 8'd3,  EXP_ON},
  '{1'b0, 1'b1, 1'b0, 16'h0000, 16'h0000, 1'b0, 1'b0, 8'd3,  EXP_ON},
  '{1'b0, 1'b0, 1'b1, 16'h0000, 16'h0000, 1'b0, 1'b0, 8'd3,  EXP_ON},
  '{1'b1, 1'b1, 1'b1, 16'h0000, 16'h0000, 1'b0, 1'b0, 8'd3,  EXP_ON},
  // fast pulses, clears and a set meeting its clear
  '{1'b0, 1'b0, 1'b0, 16'h0001, 16'h0000, 1'b0, 1'b0, 8'd4,  EXP_ON},
  '{1'b0, 1'b0, 1'b0, 16'h8000, 16'h0000, 1'b0, 1'b0, 8'd3,  EXP_ON},
  '{1'b0, 1'b0, 1'b0, 16'h00f0, 16'h0001, 1'b0, 1'b0, 8'd3,  EXP_ON},
  '{1'b0, 1'b0, 1'b0, 16'h0100, 16'h0100, 1'b0, 1'b0, 8'd3,  EXP_ON},
  '{1'b0, 1'b0, 1'b0, 16'h0000, 16'hffff, 1'b0, 1'b0, 8'd3,  EXP_ON},
  '{1'b0, 1'b0, 1'b0, 16'h5a5a, 16'h0000, 1'b0, 1'b0, 8'd3,  EXP_ON},
  '{1'b0, 1'b0, 1'b0, 16'h0005, 16'h5a5a, 1'b0, 1'b0, 8'd3,  EXP_ON},
  '{1'b0, 1'b0, 1'b0, 16'h0000, 16'hffff, 1'b0, 1'b0, 8'd4,  EXP_ON},
  // asleep but sleep disabled, stays on
  '{1'b0, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b1, 1'b0, 8'd30, EXP_ON},
  // full power-down, then a level wakes it
  '{1'b0, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b1, 1'b1, 8'd30, EXP_OFF},
  '{1'b0, 1'b0, 1'b1, 16'h0000, 16'h0000, 1'b1, 1'b1, 8'd30, EXP_ON},
  '{1'b0, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b0, 1'b1, 8'd4,  EXP_ON},
  // timer arrives in the middle of power-down
  '{1'b0, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b1, 1'b1, 8'd8,  EXP_GOING},
  '{1'b0, 1'b1, 1'b0, 16'h0000, 16'h0000, 1'b1, 1'b1, 8'd30, EXP_ON},
  // off again, woken by a fast line
  '{1'b0, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b1, 1'b1, 8'd30, EXP_OFF},
  '{1'b0, 1'b0, 1'b0, 16'h0400, 16'h0000, 1'b1, 1'b1, 8'd30, EXP_ON},
  '{1'b0, 1'b0, 1'b0, 16'h0000, 16'h0400, 1'b0, 1'b1, 8'd4,  EXP_ON},
  // core wakes by itself during power-down
  '{1'b0, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b1, 1'b1, 8'd8,  EXP_GOING},
  '{1'b0, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b0, 1'b1, 8'd30, EXP_ON},
  '{1'b0, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b0, 1'b0, 8'd4,  EXP_ON}
};

`endif

/* bench/tb_mcu_ao_ctrl.sv */
// Self-checking bench for mcu_ao_ctrl with IDLE_CYCLES at 4.
// The power switch is modelled with an ack delay of 1 to 8 cycles from an LFSR.
// Stops at the first mismatch.

`timescale 1ns/1ps

module tb_mcu_ao_ctrl;

  localparam int          CLK_HALF      = 5;
  localparam int          RESET_CYCLES  = 10;
  localparam logic [31:0] LFSR_SEED     = 32'h2a81;
  localparam int unsigned ACK_MAX_DELAY = 8;
  localparam int          WAIT_LIMIT    = 48;
  localparam int unsigned MARGIN_CYCLES = 200;

  `include "tb_vectors.svh"

  logic                          clk_i;
  logic                          reset_i;
  logic                          irq_software_i;
  logic                          irq_timer_i;
  logic                          irq_external_i;
  logic [mcu_ao_pkg::FAST_W-1:0] fast_src_i;
  logic [mcu_ao_pkg::FAST_W-1:0] fast_clear_i;
  logic                          core_sleep_i;
  logic                          sleep_enable_i;
  logic                          switch_ack_ni = 1'b0;
  mcu_ao_pkg::irq_vec_u          irq_o;
  logic                          irq_pending_o;
  logic                          switch_no;
  logic                          iso_no;
  logic                          rst_no;
  logic                          clkgate_en_no;
  logic                          domain_on_o;
  logic                          wakeup_o;

  // switch model state
  logic [31:0] lfsr_state = LFSR_SEED;
  logic        ack_target = 1'b0;
  int unsigned ack_count  = 0;

  // reference model state
  logic [mcu_ao_pkg::FAST_W-1:0] exp_fast  = '0;
  logic                          exp_sw    = 1'b0;
  logic                          exp_timer = 1'b0;
  logic                          exp_ext   = 1'b0;
  int                            phase     = 0;

  mcu_ao_ctrl #(
    .IDLE_CYCLES(4)
  ) uut (
    .clk_i,
    .reset_i,
    .irq_software_i,
    .irq_timer_i,
    .irq_external_i,
    .fast_src_i,
    .fast_clear_i,
    .core_sleep_i,
    .sleep_enable_i,
    .switch_ack_ni,
    .irq_o,
    .irq_pending_o,
    .switch_no,
    .iso_no,
    .rst_no,
    .clkgate_en_no,
    .domain_on_o,
    .wakeup_o
  );

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] build_word(input logic [15:0] fast, input logic sw,
                                              input logic timer, input logic ext);
    logic [31:0] w;
    w = 32'(fast) << mcu_ao_pkg::IRQ_FAST_LSB;
    w[mcu_ao_pkg::IRQ_SW_BIT]    = sw;
    w[mcu_ao_pkg::IRQ_TIMER_BIT] = timer;
    w[mcu_ao_pkg::IRQ_EXT_BIT]   = ext;
    return w;
  endfunction

  // {clkgate_en_no, iso_no, rst_no, switch_no, domain_on_o} for each step
  function automatic logic [4:0] phase_vec(input int p);
    case (p)
      1: return 5'b01110;
      2: return 5'b00110;
      3: return 5'b00010;
      4: return 5'b00000;
      5: return 5'b00010;
      6: return 5'b00110;
      7: return 5'b01110;
      default: return 5'b11111;
    endcase
  endfunction

  task automatic abort_run();
    $display("Verification failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    if (actual !== expected) begin
      $display("error: %s is 0x%h, expected 0x%h", name, actual, expected);
      abort_run();
    end
  endtask

  task automatic wait_domain_state(input int row, input logic [1:0] want);
    int n;
    int target;
    n = 0;
    target = (want == EXP_ON) ? 0 : 4;
    if (want == EXP_GOING) begin
      if (phase < 1 || phase > 4) begin
        $display("row %0d: the domain did not start to power down", row);
        abort_run();
      end
    end else begin
      while (phase != target && n < WAIT_LIMIT) begin
        @(posedge clk_i);
        n++;
      end
      if (phase != target) begin
        $display("row %0d: the domain did not reach the expected power state in time", row);
        abort_run();
      end
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever begin
      #CLK_HALF clk_i = ~clk_i;
    end
  end

  // ack follows the switch, low while the domain has power
  always @(posedge clk_i) begin : switch_model
    int unsigned delay;
    int          i;
    if (reset_i) begin
      ack_target    <= 1'b0;
      ack_count     <= 0;
      switch_ack_ni <= 1'b0;
    end else if (ack_count != 0) begin
      if (ack_count == 1) begin
        switch_ack_ni <= ack_target;
      end
      ack_count <= ack_count - 1;
    end else if (switch_no == ack_target) begin
      delay = 0;
      for (i = 0; i < 3; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        delay = (delay << 1) | 32'(lfsr_state[0]);
      end
      ack_target <= ~switch_no;
      // the change is seen one cycle late, so a zero draw answers at once
      if (delay == 0) begin
        switch_ack_ni <= ~switch_no;
      end
      ack_count <= delay;
    end
  end

  // outputs are stable at the falling edge
  always @(negedge clk_i) begin : monitor
    logic [31:0] exp_word;
    logic [4:0]  pwr;
    logic        woke;
    int          b;
    exp_word = build_word(exp_fast, exp_sw, exp_timer, exp_ext);
    compare_value("irq_o", irq_o.raw, exp_word);
    compare_value("irq_pending_o", 32'(irq_pending_o), 32'(|exp_word));

    pwr = {clkgate_en_no, iso_no, rst_no, switch_no, domain_on_o};
    woke = 1'b0;
    if (pwr != phase_vec(phase)) begin
      woke = (phase == 7);
      phase = (phase == 7) ? 0 : phase + 1;
    end
    compare_value("power outputs", 32'(pwr), 32'(phase_vec(phase)));
    compare_value("wakeup_o", 32'(wakeup_o), 32'(woke));

    // word for the next edge, set wins over clear
    if (reset_i) begin
      exp_fast  = '0;
      exp_sw    = 1'b0;
      exp_timer = 1'b0;
      exp_ext   = 1'b0;
    end else begin
      for (b = 0; b < mcu_ao_pkg::FAST_W; b++) begin
        if (fast_src_i[b]) begin
          exp_fast[b] = 1'b1;
        end else if (fast_clear_i[b]) begin
          exp_fast[b] = 1'b0;
        end
      end
      exp_sw    = irq_software_i;
      exp_timer = irq_timer_i;
      exp_ext   = irq_external_i;
    end
  end

  initial begin : watchdog
    int unsigned limit;
    int          r;
    limit = RESET_CYCLES + MARGIN_CYCLES;
    for (r = 0; r < N_ROWS; r++) begin
      limit = limit + 32'(VECTORS[r].cycles) + ACK_MAX_DELAY;
    end
    repeat (limit) @(posedge clk_i);
    $display("timeout: the run did not finish within %0d cycles", limit);
    abort_run();
  end

  initial begin : stimulus
    int r;
    reset_i        = 1'b1;
    irq_software_i = 1'b0;
    irq_timer_i    = 1'b0;
    irq_external_i = 1'b0;
    fast_src_i     = '0;
    fast_clear_i   = '0;
    core_sleep_i   = 1'b0;
    sleep_enable_i = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    reset_i <= 1'b0;

    for (r = 0; r < N_ROWS; r++) begin
      irq_software_i <= VECTORS[r].sw;
      irq_timer_i    <= VECTORS[r].timer;
      irq_external_i <= VECTORS[r].ext;
      fast_src_i     <= VECTORS[r].fast_set;
      fast_clear_i   <= VECTORS[r].fast_clr;
      core_sleep_i   <= VECTORS[r].sleep;
      sleep_enable_i <= VECTORS[r].sleep_en;
      @(posedge clk_i);
      // masks are single-cycle pulses
      fast_src_i   <= '0;
      fast_clear_i <= '0;
      repeat (VECTORS[r].cycles - 8'd1) @(posedge clk_i);
      wait_domain_state(r, VECTORS[r].expect_dom);
    end

    repeat (2) @(posedge clk_i);
    $display("Verification passed");
    $finish;
  end

endmodule

/* all.f */
+incdir+bench
design/mcu_ao_pkg.sv
design/irq_collector.sv
design/power_domain_seq.sv
design/wake_ctrl.sv
design/mcu_ao_ctrl.sv
bench/tb_mcu_ao_ctrl.sv

/* Makefile */
TOP := tb_mcu_ao_ctrl

.PHONY: sim clean

sim:
	verilator --binary --timing -f all.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir
